//--- mem_sys.f
axi_mem_pkg.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
axi_slave_mem.sv
mem_client.sv
mem_sys.sv
mem_sys_sva.sv
tb_mem_sys.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_sys
FILELIST   := mem_sys.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir
PASS_MSG   := Finished with no errors
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qFx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mem_sys.sv
module tb_mem_sys;
    timeunit 1ns;
    timeprecision 100ps;
    import axi_mem_pkg::*;

    localparam int TIMEOUT   = 64;                    // cycles per wait
    localparam int MEM_BYTES = MEM_WORDS * STRB_W;

    logic              clock = 1'b0;
    logic              reset;
    logic              req;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        size;
    logic [LEN_W-1:0]  len;
    logic [DATA_W-1:0] wdata;
    logic              ready;
    logic              done;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic              rlast;

    logic [7:0]        shadow [MEM_BYTES];            // byte image of the array
    logic [DATA_W-1:0] exp_data_q [$];
    logic              exp_last_q [$];
    logic [DATA_W-1:0] exp_data;
    logic              exp_last;
    int                beat_count;
    int                errors = 0;
    int                checks = 0;
    int                tests_run = 0;
    int                mark_checks = 0;
    int                mark_errors = 0;

    mem_sys i_mem_sys (
        .clock  (clock),
        .reset  (reset),
        .req    (req),
        .write  (write),
        .addr   (addr),
        .size   (size),
        .len    (len),
        .wdata  (wdata),
        .ready  (ready),
        .done   (done),
        .rvalid (rvalid),
        .rdata  (rdata),
        .rlast  (rlast)
    );

    always #2 clock = ~clock;

    // expected beat: narrow single beats zero-extended, bursts walk doublewords
    function automatic logic [DATA_W-1:0] expect_beat(input logic [ADDR_W-1:0] a,
            input logic [1:0] sz, input logic [LEN_W-1:0] ln, input int beat);
        logic [DATA_W-1:0] value;
        int                nbytes;
        int                base;
        value = '0;
        if (ln == '0) begin
            nbytes = 1 << sz;
            base   = int'(a[10:0]);
        end else begin
            nbytes = STRB_W;
            base   = ((int'(a[10:3]) + beat) % MEM_WORDS) * STRB_W;
        end
        for (int i = 0; i < nbytes; i++) begin
            value[i*8 +: 8] = shadow[(base + i) % MEM_BYTES];
        end
        return value;
    endfunction

    // beats are checked mid-cycle
    always @(negedge clock) begin
        if (!reset && rvalid) begin
            beat_count++;
            if (exp_data_q.size() == 0) begin
                $display("error %0t: read beat arrived with no read outstanding", $time);
                errors++;
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_last = exp_last_q.pop_front();
                checks += 2;
                assert (rdata === exp_data) else begin
                    $display("error %0t rdata: got %h expected %h", $time, rdata, exp_data);
                    errors++;
                end
                assert (rlast === exp_last) else begin
                    $display("error %0t rlast: got %b expected %b", $time, rlast, exp_last);
                    errors++;
                end
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not arrive within %0d cycles at %0t", what, TIMEOUT, $time);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic wait_ready();
        int t = 0;
        @(negedge clock);
        while (!ready) begin
            if (t >= TIMEOUT) begin
                abort_on_timeout("ready");
            end
            @(negedge clock);
            t++;
        end
    endtask

    task automatic drive_request(input logic wr, input logic [ADDR_W-1:0] a,
            input logic [1:0] sz, input logic [LEN_W-1:0] ln, input logic [DATA_W-1:0] d);
        @(posedge clock);
        req   <= 1'b1;
        write <= wr;
        addr  <= a;
        size  <= sz;
        len   <= ln;
        wdata <= d;
        @(posedge clock);
        req <= 1'b0;
    endtask

    task automatic store(input logic [ADDR_W-1:0] a, input logic [1:0] sz,
            input logic [DATA_W-1:0] d);
        int t = 0;
        wait_ready();
        for (int i = 0; i < (1 << sz); i++) begin
            shadow[(int'(a[10:0]) + i) % MEM_BYTES] = d[i*8 +: 8];
        end
        drive_request(1'b1, a, sz, '0, d);
        @(negedge clock);
        while (!done) begin
            if (t >= TIMEOUT) begin
                abort_on_timeout("done after a write");
            end
            @(negedge clock);
            t++;
        end
    endtask

    task automatic load(input logic [ADDR_W-1:0] a, input logic [1:0] sz,
            input logic [LEN_W-1:0] ln);
        wait_ready();
        beat_count = 0;
        for (int b = 0; b <= int'(ln); b++) begin
            exp_data_q.push_back(expect_beat(a, sz, ln, b));
            exp_last_q.push_back(b == int'(ln));
        end
        drive_request(1'b0, a, sz, ln, '0);
        wait_ready();   // ready returns after the last beat
        checks++;
        assert (beat_count == int'(ln) + 1) else begin
            $display("error %0t beat_count: got %0d expected %0d", $time, beat_count,
                int'(ln) + 1);
            errors++;
        end
        exp_data_q.delete();
        exp_last_q.delete();
    endtask

    task automatic check_output(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("error %0t %s: got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d checks, %0d errors", tests_run, name,
            checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic check_reset_state();
        check_output("ready", ready, 1'b1);
        check_output("done", done, 1'b0);
        check_output("rvalid", rvalid, 1'b0);
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        logic [1:0]        sz;
        int                start;
        reset = 1'b1;
        req   = 1'b0;
        write = 1'b0;
        addr  = '0;
        size  = '0;
        len   = '0;
        wdata = '0;
        void'($urandom(32'hebab8c50));
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_reset_state();
        report_test("reset state");

        for (int i = 0; i < 32; i++) begin
            store(32'(i) << 3, SIZE_D, {$urandom, $urandom});
        end
        for (int i = 0; i < 32; i++) begin
            load(32'(i) << 3, SIZE_D, '0);
        end
        report_test("doubleword stores and loads");

        repeat (24) begin
            sz = 2'($urandom_range(2));
            a  = ($urandom_range(255) >> sz) << sz;   // naturally aligned
            store(a, sz, {$urandom, $urandom});
            load({a[ADDR_W-1:3], 3'b000}, SIZE_D, '0);
        end
        report_test("narrow stores");

        repeat (24) begin
            sz = 2'($urandom_range(2));
            a  = ($urandom_range(255) >> sz) << sz;
            load(a, sz, '0);
        end
        report_test("narrow loads");

        for (int ln = 0; ln < 16; ln++) begin
            start = $urandom_range(31 - ln);            // stays inside written words
            load(32'(start) << 3, SIZE_D, 4'(ln));
        end
        report_test("bursts");

        repeat (6) begin
            a = (32'($urandom_range(15, 1)) << 11) | (32'($urandom_range(255)) << 3);
            store(a, SIZE_D, {$urandom, $urandom});
            load(a & 32'h0000_07ff, SIZE_D, '0);       // alias below 2 KiB
        end
        report_test("address wrap");

        @(posedge clock);
        reset <= 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_reset_state();
        store(32'h0000_0040, SIZE_W, {$urandom, $urandom});
        load(32'h0000_0040, SIZE_D, '0);
        load(32'h0000_0000, SIZE_D, 4'd3);              // array kept its contents
        report_test("reset mid-run");

        errors += i_mem_sys.i_axi_slave_mem.i_mem_sys_sva.assert_fails;
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- mem_sys_sva.sv
module mem_sys_sva (
    input logic clock,
    input logic reset,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic arvalid,
    input logic arready,
    input logic rvalid,
    input logic rlast
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;   // read by the testbench at the end

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before its handshake");
            assert_fails++;
        end

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before its handshake");
            assert_fails++;
        end

    // last beat closes the burst
    last_with_valid: assert property (@(posedge clock) disable iff (reset)
        rlast |-> rvalid ##1 !rvalid)
        else begin
            $error("rlast seen without rvalid or the burst went on after it");
            assert_fails++;
        end

    // response one cycle after the W beat
    resp_after_w: assert property (@(posedge clock) disable iff (reset)
        $rose(bvalid) |-> $past(wvalid && wready))
        else begin
            $error("bvalid raised without a preceding W handshake");
            assert_fails++;
        end

    // controllers come out of reset idle, so a new valid waits a cycle for ready
    ready_after_reset: assert property (@(posedge clock) disable iff (reset)
        (!$rose(awvalid) || !awready) && (!$rose(arvalid) || !arready))
        else begin
            $error("a ready output rose together with its valid");
            assert_fails++;
        end

endmodule

bind axi_slave_mem mem_sys_sva i_mem_sys_sva (
    .clock   (clock),
    .reset   (reset),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rlast   (rlast)
);

//--- mem_sys.sv
module mem_sys (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             req,
    input  logic                             write,
    input  logic [axi_mem_pkg::ADDR_W-1:0]   addr,
    input  logic [1:0]                       size,
    input  logic [axi_mem_pkg::LEN_W-1:0]    len,
    input  logic [axi_mem_pkg::DATA_W-1:0]   wdata,
    output logic                             ready,
    output logic                             done,
    output logic                             rvalid,
    output logic [axi_mem_pkg::DATA_W-1:0]   rdata,
    output logic                             rlast
);
    import axi_mem_pkg::*;

    logic              axi_awvalid;
    logic              axi_awready;
    logic [ADDR_W-1:0] axi_awaddr;
    logic [1:0]        axi_awsize;
    logic              axi_wvalid;
    logic              axi_wready;
    mem_beat_u         axi_wdata;
    logic [STRB_W-1:0] axi_wstrb;
    logic              axi_bready;
    logic              axi_bvalid;
    logic              axi_arvalid;
    logic              axi_arready;
    logic [ADDR_W-1:0] axi_araddr;
    logic [LEN_W-1:0]  axi_arlen;
    logic              axi_rready;
    logic              axi_rvalid;
    mem_beat_u         axi_rdata;
    logic              axi_rlast;

    mem_client i_mem_client (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .write      (write),
        .addr       (addr),
        .size       (size),
        .len        (len),
        .wdata      (wdata),
        .ready      (ready),
        .done       (done),
        .rvalid_out (rvalid),
        .rdata_out  (rdata),
        .rlast_out  (rlast),
        .awvalid    (axi_awvalid),
        .awready    (axi_awready),
        .awaddr     (axi_awaddr),
        .awsize     (axi_awsize),
        .wvalid     (axi_wvalid),
        .wready     (axi_wready),
        .wbeat      (axi_wdata),
        .wstrb      (axi_wstrb),
        .bready     (axi_bready),
        .bvalid     (axi_bvalid),
        .arvalid    (axi_arvalid),
        .arready    (axi_arready),
        .araddr     (axi_araddr),
        .arlen      (axi_arlen),
        .rready     (axi_rready),
        .rvalid     (axi_rvalid),
        .rdata      (axi_rdata),
        .rlast      (axi_rlast)
    );

    axi_slave_mem i_axi_slave_mem (
        .clock   (clock),
        .reset   (reset),
        .awvalid (axi_awvalid),
        .awready (axi_awready),
        .awaddr  (axi_awaddr),
        .awsize  (axi_awsize),
        .wvalid  (axi_wvalid),
        .wready  (axi_wready),
        .wdata   (axi_wdata),
        .wstrb   (axi_wstrb),
        .bready  (axi_bready),
        .bvalid  (axi_bvalid),
        .arvalid (axi_arvalid),
        .arready (axi_arready),
        .araddr  (axi_araddr),
        .arlen   (axi_arlen),
        .rready  (axi_rready),
        .rvalid  (axi_rvalid),
        .rdata   (axi_rdata),
        .rlast   (axi_rlast)
    );

endmodule

//--- mem_client.sv
module mem_client (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             req,
    input  logic                             write,
    input  logic [axi_mem_pkg::ADDR_W-1:0]   addr,
    input  logic [1:0]                       size,
    input  logic [axi_mem_pkg::LEN_W-1:0]    len,
    input  logic [axi_mem_pkg::DATA_W-1:0]   wdata,
    output logic                             ready,
    output logic                             done,
    output logic                             rvalid_out,
    output logic [axi_mem_pkg::DATA_W-1:0]   rdata_out,
    output logic                             rlast_out,
    output logic                             awvalid,
    input  logic                             awready,
    output logic [axi_mem_pkg::ADDR_W-1:0]   awaddr,
    output logic [1:0]                       awsize,
    output logic                             wvalid,
    input  logic                             wready,
    output axi_mem_pkg::mem_beat_u           wbeat,
    output logic [axi_mem_pkg::STRB_W-1:0]   wstrb,
    output logic                             bready,
    input  logic                             bvalid,
    output logic                             arvalid,
    input  logic                             arready,
    output logic [axi_mem_pkg::ADDR_W-1:0]   araddr,
    output logic [axi_mem_pkg::LEN_W-1:0]    arlen,
    output logic                             rready,
    input  logic                             rvalid,
    input  axi_mem_pkg::mem_beat_u           rdata,
    input  logic                             rlast
);
    import axi_mem_pkg::*;

    logic              busy;
    logic              write_q;
    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        size_q;
    logic [LEN_W-1:0]  len_q;
    logic [DATA_W-1:0] wdata_q;
    mem_beat_u         shifted;

    assign ready  = !busy;
    assign bready = busy && write_q;
    assign rready = busy && !write_q;
    assign done   = bready && bvalid;

    assign awaddr = addr_q;
    assign awsize = size_q;
    assign araddr = addr_q;
    assign arlen  = len_q;
    assign wstrb  = size_mask(size_q) << addr_q[2:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            busy    <= 1'b0;
            write_q <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else if (req && !busy) begin
            busy    <= 1'b1;
            write_q <= write;
            awvalid <= write;
            wvalid  <= write;   // W offered together with AW
            arvalid <= !write;
        end else begin
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (done || (rvalid && rready && rlast)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req && !busy) begin
            addr_q  <= addr;
            size_q  <= size;
            len_q   <= len;
            wdata_q <= wdata;
        end
    end

    // replicate the low bytes into every lane
    always_comb begin
        case (size_q)
            SIZE_B:  wbeat.bytes = {STRB_W{wdata_q[7:0]}};
            SIZE_H:  wbeat.word = {2{wdata_q[15:0], wdata_q[15:0]}};
            SIZE_W:  wbeat.word = {wdata_q[31:0], wdata_q[31:0]};
            default: wbeat = wdata_q;
        endcase
    end

    assign shifted    = rdata >> {addr_q[2:0], 3'b000};
    assign rvalid_out = rvalid;
    assign rlast_out  = rlast;

    // single beats are aligned down and zero-extended, burst beats pass as is
    always_comb begin
        rdata_out = rdata;
        if (len_q == '0) begin
            case (size_q)
                SIZE_B:  rdata_out = {56'd0, shifted.bytes[0]};
                SIZE_H:  rdata_out = {48'd0, shifted.bytes[1], shifted.bytes[0]};
                SIZE_W:  rdata_out = {32'd0, shifted.word[0]};
                default: rdata_out = shifted;
            endcase
        end
    end

endmodule

//--- axi_slave_mem.sv
module axi_slave_mem (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]   awaddr,
    input  logic [1:0]                       awsize,
    input  logic                             wvalid,
    output logic                             wready,
    input  axi_mem_pkg::mem_beat_u           wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]   wstrb,
    input  logic                             bready,
    output logic                             bvalid,
    input  logic                             arvalid,
    output logic                             arready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]   araddr,
    input  logic [axi_mem_pkg::LEN_W-1:0]    arlen,
    input  logic                             rready,
    output logic                             rvalid,
    output axi_mem_pkg::mem_beat_u           rdata,
    output logic                             rlast
);
    import axi_mem_pkg::*;

    mem_beat_u         mem [MEM_WORDS];
    logic [STRB_W-1:0] we;
    logic [IDX_W-1:0]  widx;
    mem_beat_u         wbeat;
    logic [IDX_W-1:0]  ridx;
    logic [1:0]        wsize_q;
    logic [2:0]        woff_q;
    logic [STRB_W-1:0] lane_mask;

    axi_write_ctrl i_write_ctrl (
        .clock   (clock),
        .reset   (reset),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bready  (bready),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .we      (we),
        .widx    (widx),
        .wbeat   (wbeat)
    );

    axi_read_ctrl i_read_ctrl (
        .clock   (clock),
        .reset   (reset),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arlen   (arlen),
        .rready  (rready),
        .arready (arready),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .ridx    (ridx)
    );

    // size and offset of the pending write
    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            wsize_q <= awsize;
            woff_q  <= awaddr[2:0];
        end
    end

    // strobes outside the sized window are ignored
    assign lane_mask = size_mask(wsize_q) << woff_q;

    always_ff @(posedge clock) begin
        for (int i = 0; i < STRB_W; i++) begin
            if (we[i] && lane_mask[i]) begin
                mem[widx].bytes[i] <= wbeat.bytes[i];
            end
        end
    end

    assign rdata = mem[ridx];   // async read

endmodule

//--- axi_read_ctrl.sv
module axi_read_ctrl (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             arvalid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]   araddr,
    input  logic [axi_mem_pkg::LEN_W-1:0]    arlen,
    input  logic                             rready,
    output logic                             arready,
    output logic                             rvalid,
    output logic                             rlast,
    output logic [axi_mem_pkg::IDX_W-1:0]    ridx
);
    import axi_mem_pkg::*;

    logic [1:0]       state;
    logic [LEN_W-1:0] cnt;
    logic [LEN_W-1:0] len_q;
    logic [IDX_W-1:0] idx_q;

    assign arready = (state == R_ADDR) && arvalid;
    assign rvalid  = (state == R_DATA) && rready;
    assign rlast   = rvalid && (cnt == len_q);
    assign ridx    = idx_q;

    // burst address, one doubleword per beat
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            idx_q <= araddr[IDX_W+2:3];
            len_q <= arlen;
        end else if (rvalid) begin
            idx_q <= idx_q + 1'b1;   // INCR, wraps with the array
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= R_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    cnt <= '0;
                    if (arvalid) begin
                        state <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (arvalid && arready) begin
                        state <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (rvalid) begin
                        cnt <= cnt + 1'b1;
                        if (rlast) begin
                            cnt   <= '0;
                            state <= R_IDLE;
                        end
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

endmodule

//--- axi_write_ctrl.sv
module axi_write_ctrl (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             awvalid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]   awaddr,
    input  logic                             wvalid,
    input  axi_mem_pkg::mem_beat_u           wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]   wstrb,
    input  logic                             bready,
    output logic                             awready,
    output logic                             wready,
    output logic                             bvalid,
    output logic [axi_mem_pkg::STRB_W-1:0]   we,
    output logic [axi_mem_pkg::IDX_W-1:0]    widx,
    output axi_mem_pkg::mem_beat_u           wbeat
);
    import axi_mem_pkg::*;

    logic [1:0]       state;
    logic [IDX_W-1:0] idx_q;

    // ready only in the matching state and while valid is up
    assign awready = (state == W_ADDR) && awvalid;
    assign wready  = (state == W_DATA) && wvalid;
    assign bvalid  = (state == W_RESP) && bready;

    assign we   = wready ? wstrb : '0;
    assign widx = idx_q;

    // unstrobed lanes are zeroed
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            wbeat.bytes[i] = wstrb[i] ? wdata.bytes[i] : 8'h00;
        end
    end

    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            idx_q <= awaddr[IDX_W+2:3];  // doubleword index, wraps at 2 KiB
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (awvalid) begin
                        state <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (awvalid && awready) begin
                        state <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (wvalid && wready) begin
                        state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (bvalid && bready) begin
                        state <= W_IDLE;
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

endmodule

//--- axi_mem_pkg.sv
package axi_mem_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 64;
    localparam int STRB_W    = DATA_W / 8;
    localparam int MEM_WORDS = 256;
    localparam int IDX_W     = $clog2(MEM_WORDS);   // addr[10:3]
    localparam int LEN_W     = 4;                   // beats minus one

    // transfer size, log2 of the byte count
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;
    localparam logic [1:0] SIZE_D = 2'd3;

    // write channel states
    localparam logic [1:0] W_IDLE = 2'd0;
    localparam logic [1:0] W_ADDR = 2'd1;
    localparam logic [1:0] W_DATA = 2'd2;
    localparam logic [1:0] W_RESP = 2'd3;

    // read channel states
    localparam logic [1:0] R_IDLE = 2'd0;
    localparam logic [1:0] R_ADDR = 2'd1;
    localparam logic [1:0] R_DATA = 2'd2;

    // one data beat, seen as word lanes or byte lanes
    typedef union packed {
        logic [1:0][DATA_W/2-1:0] word;
        logic [STRB_W-1:0][7:0]   bytes;
    } mem_beat_u;

    // byte mask of a naturally aligned access at offset zero
    function automatic logic [STRB_W-1:0] size_mask(input logic [1:0] size);
        logic [STRB_W-1:0] mask;
        case (size)
            SIZE_B:  mask = 8'h01;
            SIZE_H:  mask = 8'h03;
            SIZE_W:  mask = 8'h0f;
            default: mask = 8'hff;
        endcase
        return mask;
    endfunction

endpackage
